/* include/poker_cfg.svh */
`ifndef POKER_CFG_SVH
`define POKER_CFG_SVH

// Chip counts up to 2047
`define POKER_CHIP_W 11

// Table settings loaded at reset
`define POKER_DEF_SB 1
`define POKER_DEF_BB 2
`define POKER_DEF_STACK 200

// Configuration register address
`define POKER_CFG_ADDR_W 2

`endif

/* hdl/poker_pkg.sv */
`include "poker_cfg.svh"

package poker_pkg;

    typedef logic [`POKER_CHIP_W-1:0] chips_t;

    typedef enum logic [2:0] {
        idle,
        pre_flop,
        flop,
        turn,
        river,
        showdown
    } street_t;

    typedef enum logic [1:0] {post_blinds, sb_to_act, bb_to_act, round_done} bet_stage_t;

    typedef enum logic [1:0] {check_call, bet_raise, fold} action_kind_t;

    typedef enum logic {role_sb, role_bb} role_t;

    typedef enum logic [`POKER_CFG_ADDR_W-1:0] {addr_sb, addr_bb, addr_stack} cfg_addr_t;

    typedef enum logic [1:0] {op_pay, op_award, op_split} ledger_op_t;

    // Amount is the raise above the call
    typedef struct packed {
        action_kind_t kind;
        chips_t       amount;
    } player_action_t;

    typedef struct packed {
        logic       valid;
        ledger_op_t op;
        role_t      role;
        chips_t     amount;
    } ledger_cmd_t;

    typedef struct packed {
        chips_t sb_size;
        chips_t bb_size;
        chips_t start_stack;
    } table_cfg_t;

    // Winner 0 is player 1
    typedef struct packed {
        logic winner;
        logic draw;
    } eval_result_t;

    typedef struct packed {
        logic  valid;
        logic  draw;
        role_t role;
    } award_req_t;

endpackage

/* hdl/table_config_regs.sv */
`timescale 1ns/1ps
`include "poker_cfg.svh"

module table_config_regs
    import poker_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       cfg_we,
    input  cfg_addr_t  cfg_addr,
    input  chips_t     cfg_data,
    input  logic       hand_active,
    output table_cfg_t cfg
);

    // Settings only change between hands
    always_ff @(posedge clk) begin
        if (reset) begin
            cfg.sb_size     <= `POKER_DEF_SB;
            cfg.bb_size     <= `POKER_DEF_BB;
            cfg.start_stack <= `POKER_DEF_STACK;
        end else if (cfg_we && !hand_active) begin
            case (cfg_addr)
                addr_sb: begin
                    cfg.sb_size <= cfg_data;
                end
                addr_bb: begin
                    // Big blind never below small blind
                    cfg.bb_size <= (cfg_data < cfg.sb_size) ? cfg.sb_size : cfg_data;
                end
                addr_stack: begin
                    cfg.start_stack <= cfg_data;
                end
                default: ;
            endcase
        end
    end

endmodule

/* hdl/hand_sequencer.sv */
`timescale 1ns/1ps

module hand_sequencer
    import poker_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         action_valid,
    input  logic         ready_in,
    input  logic         round_done,
    input  logic         fold_end,
    input  logic         all_in,
    input  logic         eval_ack,
    input  eval_result_t eval_result,
    output street_t      street,
    output logic         button,
    output logic         hand_active,
    output logic         hand_start,
    output award_req_t   showdown_award,
    output logic         eval_req
);

    // Result already taken, waiting for ack to drop
    logic eval_done;

    assign hand_active = (street != idle);
    assign hand_start  = (street == idle) && action_valid && ready_in;

    always_ff @(posedge clk) begin
        if (reset) begin
            street         <= idle;
            button         <= 1'b0;
            eval_req       <= 1'b0;
            eval_done      <= 1'b0;
            showdown_award <= '0;
        end else begin
            showdown_award.valid <= 1'b0;
            case (street)
                idle: begin
                    if (hand_start) begin
                        street <= pre_flop;
                    end
                end
                pre_flop, flop, turn, river: begin
                    if (round_done) begin
                        if (fold_end) begin
                            street <= idle;
                            button <= ~button;
                        end else if (all_in || street == river) begin
                            street   <= showdown;
                            eval_req <= 1'b1;
                        end else begin
                            street <= street_t'(street + 3'd1);
                        end
                    end
                end
                showdown: begin
                    if (eval_req && eval_ack) begin
                        eval_req       <= 1'b0;
                        eval_done      <= 1'b1;
                        // Seat winner to role: player 2 is sb when button is high
                        showdown_award <= '{
                            valid: 1'b1,
                            draw:  eval_result.draw,
                            role:  role_t'(eval_result.winner ^ button)
                        };
                    end else if (eval_done && !eval_ack) begin
                        eval_done <= 1'b0;
                        street    <= idle;
                        button    <= ~button;
                    end
                end
                default: begin
                    street <= idle;
                end
            endcase
        end
    end

endmodule

/* hdl/betting_round.sv */
`timescale 1ns/1ps

module betting_round
    import poker_pkg::*;
(
    input  logic           clk,
    input  logic           reset,
    input  street_t        street,
    input  logic           hand_start,
    input  logic           action_valid,
    input  player_action_t action,
    input  table_cfg_t     cfg,
    input  chips_t         sb_stack,
    input  chips_t         bb_stack,
    input  award_req_t     showdown_award,
    output logic           ready,
    output role_t          to_act,
    output chips_t         pot,
    output chips_t         call_amount,
    output chips_t         min_raise,
    output logic           round_done,
    output logic           fold_end,
    output logic           all_in,
    output ledger_cmd_t    ledger_cmd
);

    localparam int CW = $bits(chips_t);

    bet_stage_t  stage;
    chips_t      sb_inv;
    chips_t      bb_inv;
    logic        both_played;
    logic        folded;
    logic        act_now;
    chips_t      actor_inv;
    chips_t      other_inv;
    chips_t      actor_stack;
    chips_t      raise_amt;
    chips_t      call_pay;
    chips_t      raise_pay;

    // Payment limited to what the player still has
    function automatic chips_t cap(input logic [CW:0] want, input chips_t limit);
        if (want > {1'b0, limit}) begin
            return limit;
        end
        return want[CW-1:0];
    endfunction

    assign to_act      = (stage == bb_to_act) ? role_bb : role_sb;
    assign actor_inv   = (stage == bb_to_act) ? bb_inv : sb_inv;
    assign other_inv   = (stage == bb_to_act) ? sb_inv : bb_inv;
    assign actor_stack = (stage == bb_to_act) ? bb_stack : sb_stack;
    assign call_amount = (other_inv > actor_inv) ? other_inv - actor_inv : '0;

    assign ready      = (street == idle) || (stage == sb_to_act) || (stage == bb_to_act);
    assign act_now    = action_valid && ((stage == sb_to_act) || (stage == bb_to_act));
    assign round_done = (stage == poker_pkg::round_done);
    assign fold_end   = folded;
    assign all_in     = ((sb_stack == '0) || (bb_stack == '0)) && !folded;

    // Raise below the minimum is lifted to it
    assign raise_amt = (action.amount < min_raise) ? min_raise : action.amount;
    assign call_pay  = cap({1'b0, call_amount}, actor_stack);
    assign raise_pay = cap({1'b0, call_amount} + {1'b0, raise_amt}, actor_stack);

    // One ledger command per cycle, applied on the same edge as the pot
    always_comb begin
        ledger_cmd = '0;
        if (stage == post_blinds) begin
            ledger_cmd.valid = 1'b1;
            ledger_cmd.op    = op_pay;
            if (!both_played) begin
                ledger_cmd.role   = role_sb;
                ledger_cmd.amount = cap({1'b0, cfg.sb_size}, sb_stack);
            end else begin
                ledger_cmd.role   = role_bb;
                ledger_cmd.amount = cap({1'b0, cfg.bb_size}, bb_stack);
            end
        end else if (act_now) begin
            ledger_cmd.valid = 1'b1;
            case (action.kind)
                check_call: begin
                    ledger_cmd.op     = op_pay;
                    ledger_cmd.role   = to_act;
                    ledger_cmd.amount = call_pay;
                end
                bet_raise: begin
                    ledger_cmd.op     = op_pay;
                    ledger_cmd.role   = to_act;
                    ledger_cmd.amount = raise_pay;
                end
                fold: begin
                    ledger_cmd.op     = op_award;
                    ledger_cmd.role   = role_t'(~to_act);
                    ledger_cmd.amount = pot;
                end
                default: begin
                    ledger_cmd.valid = 1'b0;
                end
            endcase
        end else if (showdown_award.valid) begin
            ledger_cmd.valid  = 1'b1;
            ledger_cmd.op     = showdown_award.draw ? op_split : op_award;
            ledger_cmd.role   = showdown_award.role;
            ledger_cmd.amount = pot;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            stage       <= poker_pkg::round_done;
            sb_inv      <= '0;
            bb_inv      <= '0;
            pot         <= '0;
            min_raise   <= '0;
            both_played <= 1'b0;
            folded      <= 1'b0;
        end else begin
            if (ledger_cmd.valid) begin
                if (ledger_cmd.op == op_pay) begin
                    pot <= pot + ledger_cmd.amount;
                    if (ledger_cmd.role == role_sb) begin
                        sb_inv <= sb_inv + ledger_cmd.amount;
                    end else begin
                        bb_inv <= bb_inv + ledger_cmd.amount;
                    end
                end else begin
                    pot <= '0;
                end
            end

            if (hand_start) begin
                stage       <= post_blinds;
                sb_inv      <= '0;
                bb_inv      <= '0;
                min_raise   <= cfg.bb_size;
                both_played <= 1'b0;
                folded      <= 1'b0;
            end else begin
                case (stage)
                    post_blinds: begin
                        // both_played marks the small blind as posted here
                        both_played <= ~both_played;
                        if (both_played) begin
                            stage <= sb_to_act;
                        end
                    end
                    sb_to_act, bb_to_act: begin
                        if (action_valid) begin
                            both_played <= 1'b1;
                            case (action.kind)
                                check_call: begin
                                    if (both_played) begin
                                        stage <= poker_pkg::round_done;
                                    end else begin
                                        stage <= (stage == sb_to_act) ? bb_to_act : sb_to_act;
                                    end
                                end
                                bet_raise: begin
                                    min_raise <= raise_amt;
                                    stage     <= (stage == sb_to_act) ? bb_to_act : sb_to_act;
                                end
                                fold: begin
                                    folded <= 1'b1;
                                    stage  <= poker_pkg::round_done;
                                end
                                default: ;
                            endcase
                        end
                    end
                    default: begin
                        // New street: big blind opens with fresh investments
                        if (!folded && !all_in &&
                            (street == pre_flop || street == flop || street == turn)) begin
                            stage       <= bb_to_act;
                            sb_inv      <= '0;
                            bb_inv      <= '0;
                            min_raise   <= cfg.bb_size;
                            both_played <= 1'b0;
                        end
                    end
                endcase
            end
        end
    end

endmodule

/* hdl/chip_ledger.sv */
`timescale 1ns/1ps

module chip_ledger
    import poker_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        button,
    input  logic        hand_start,
    input  table_cfg_t  cfg,
    input  ledger_cmd_t ledger_cmd,
    output chips_t      sb_stack,
    output chips_t      bb_stack,
    output chips_t      p1_stack,
    output chips_t      p2_stack
);

    chips_t sb_next;
    chips_t bb_next;
    chips_t half;

    // Button high puts player 2 on the small blind
    assign sb_stack = button ? p2_stack : p1_stack;
    assign bb_stack = button ? p1_stack : p2_stack;

    // Odd chip of a split stays with the big blind
    assign half = ledger_cmd.amount >> 1;

    always_comb begin
        sb_next = sb_stack;
        bb_next = bb_stack;
        if (ledger_cmd.valid) begin
            case (ledger_cmd.op)
                op_pay: begin
                    if (ledger_cmd.role == role_sb) begin
                        sb_next = sb_stack - ledger_cmd.amount;
                    end else begin
                        bb_next = bb_stack - ledger_cmd.amount;
                    end
                end
                op_award: begin
                    if (ledger_cmd.role == role_sb) begin
                        sb_next = sb_stack + ledger_cmd.amount;
                    end else begin
                        bb_next = bb_stack + ledger_cmd.amount;
                    end
                end
                op_split: begin
                    sb_next = sb_stack + half;
                    bb_next = bb_stack + (ledger_cmd.amount - half);
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            p1_stack <= '0;
            p2_stack <= '0;
        end else if (hand_start && (p1_stack == '0 || p2_stack == '0)) begin
            p1_stack <= cfg.start_stack;
            p2_stack <= cfg.start_stack;
        end else begin
            p1_stack <= button ? bb_next : sb_next;
            p2_stack <= button ? sb_next : bb_next;
        end
    end

endmodule

/* hdl/poker_table_top.sv */
`timescale 1ns/1ps

module poker_table_top
    import poker_pkg::*;
(
    input  logic           clk,
    input  logic           reset,
    input  logic           action_valid,
    input  player_action_t action,
    input  logic           cfg_we,
    input  cfg_addr_t      cfg_addr,
    input  chips_t         cfg_data,
    input  logic           eval_ack,
    input  eval_result_t   eval_result,
    output logic           ready,
    output street_t        street,
    output logic           button,
    output role_t          to_act,
    output chips_t         pot,
    output chips_t         call_amount,
    output chips_t         min_raise,
    output chips_t         p1_stack,
    output chips_t         p2_stack,
    output logic           eval_req
);

    table_cfg_t  cfg;
    logic        hand_active;
    logic        hand_start;
    logic        round_done;
    logic        fold_end;
    logic        all_in;
    award_req_t  showdown_award;
    ledger_cmd_t ledger_cmd;
    chips_t      sb_stack;
    chips_t      bb_stack;

    table_config_regs u_cfg (
        .clk,
        .reset,
        .cfg_we,
        .cfg_addr,
        .cfg_data,
        .hand_active,
        .cfg
    );

    hand_sequencer u_seq (
        .clk,
        .reset,
        .action_valid,
        .ready_in (ready),
        .round_done,
        .fold_end,
        .all_in,
        .eval_ack,
        .eval_result,
        .street,
        .button,
        .hand_active,
        .hand_start,
        .showdown_award,
        .eval_req
    );

    betting_round u_bet (
        .clk,
        .reset,
        .street,
        .hand_start,
        .action_valid,
        .action,
        .cfg,
        .sb_stack,
        .bb_stack,
        .showdown_award,
        .ready,
        .to_act,
        .pot,
        .call_amount,
        .min_raise,
        .round_done,
        .fold_end,
        .all_in,
        .ledger_cmd
    );

    chip_ledger u_ledger (
        .clk,
        .reset,
        .button,
        .hand_start,
        .cfg,
        .ledger_cmd,
        .sb_stack,
        .bb_stack,
        .p1_stack,
        .p2_stack
    );

endmodule

/* verification/poker_table_asserts.sv */
`timescale 1ns/1ps

module poker_table_asserts
    import poker_pkg::*;
(
    input logic    clk,
    input logic    reset,
    input logic    ready,
    input logic    eval_req,
    input logic    eval_ack,
    input street_t street,
    input chips_t  pot,
    input chips_t  p1_stack,
    input chips_t  p2_stack
);

    // Sum of pot and both stacks needs two extra bits
    logic [$bits(chips_t)+1:0] total;
    int fail_count = 0;

    assign total = pot + p1_stack + p2_stack;

    // No player input while the evaluator is busy
    ready_low_during_eval: assert property (
        @(posedge clk) disable iff (reset) eval_req |-> !ready
    ) else begin
        fail_count++;
        $error("ready is high while eval_req is high");
    end

    // Request held until acknowledged
    eval_req_held: assert property (
        @(posedge clk) disable iff (reset) (eval_req && !eval_ack) |=> eval_req
    ) else begin
        fail_count++;
        $error("eval_req dropped before eval_ack");
    end

    // Every update made during a hand keeps the chips on the table
    chips_conserved: assert property (
        @(posedge clk) disable iff (reset)
        ($past(street) != idle) |-> (total == $past(total))
    ) else begin
        fail_count++;
        $error("pot plus stacks changed during a hand");
    end

endmodule

bind poker_table_top poker_table_asserts i_asserts (
    .clk      (clk),
    .reset    (reset),
    .ready    (ready),
    .eval_req (eval_req),
    .eval_ack (eval_ack),
    .street   (street),
    .pot      (pot),
    .p1_stack (p1_stack),
    .p2_stack (p2_stack)
);

/* verification/poker_table_tb.sv */
`timescale 1ns/1ps

module poker_table_tb
    import poker_pkg::*;
();

    typedef enum logic {step_act, step_cfg} step_kind_t;

    // One step: either a player action or a config write, then the expected state
    typedef struct packed {
        step_kind_t   op;
        action_kind_t kind;
        chips_t       amount;
        cfg_addr_t    addr;
        eval_result_t res;
        chips_t       exp_p1;
        chips_t       exp_p2;
        chips_t       exp_pot;
        street_t      exp_street;
        role_t        exp_to_act;
        chips_t       exp_call;
        chips_t       exp_min;
        logic         exp_button;
    } step_t;

    logic           clk = 1'b0;
    logic           reset;
    logic           action_valid;
    player_action_t action;
    logic           cfg_we;
    cfg_addr_t      cfg_addr;
    chips_t         cfg_data;
    logic           eval_ack;
    eval_result_t   eval_result;
    logic           ready;
    street_t        street;
    logic           button;
    role_t          to_act;
    chips_t         pot;
    chips_t         call_amount;
    chips_t         min_raise;
    chips_t         p1_stack;
    chips_t         p2_stack;
    logic           eval_req;

    step_t        steps[$];
    eval_result_t eval_answer;
    logic [31:0]  rand_state = 32'd19;
    int           checks = 0;
    int           mismatches = 0;
    int           cycles = 0;
    int           timeout_limit = 0;

    always #4 clk = ~clk;

    poker_table_top i_dut (.*);

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic step_t expect_row(input chips_t p1, input chips_t p2, input chips_t pt,
                                         input street_t st, input role_t role,
                                         input chips_t call, input chips_t min_r,
                                         input logic btn);
        step_t s;
        s = '0;
        s.exp_p1     = p1;
        s.exp_p2     = p2;
        s.exp_pot    = pt;
        s.exp_street = st;
        s.exp_to_act = role;
        s.exp_call   = call;
        s.exp_min    = min_r;
        s.exp_button = btn;
        return s;
    endfunction

    task automatic add_action(input action_kind_t kind, input chips_t amount,
                              input eval_result_t res, input chips_t p1, input chips_t p2,
                              input chips_t pt, input street_t st, input role_t role,
                              input chips_t call, input chips_t min_r, input logic btn);
        step_t s;
        s = expect_row(p1, p2, pt, st, role, call, min_r, btn);
        s.op     = step_act;
        s.kind   = kind;
        s.amount = amount;
        s.res    = res;
        steps.push_back(s);
    endtask

    task automatic add_config(input cfg_addr_t addr, input chips_t data, input chips_t p1,
                              input chips_t p2, input chips_t pt, input street_t st,
                              input role_t role, input chips_t call, input chips_t min_r,
                              input logic btn);
        step_t s;
        s = expect_row(p1, p2, pt, st, role, call, min_r, btn);
        s.op     = step_cfg;
        s.addr   = addr;
        s.amount = data;
        steps.push_back(s);
    endtask

    // Columns: kind or address, amount, eval result {winner, draw},
    // then p1, p2, pot, street, to_act, call_amount, min_raise, button
    task automatic build_table();
        // Hand 1, p1 small blind, checked down to a showdown won by player 2
        add_action(check_call, 0, 2'b00, 199, 198, 3, pre_flop, role_sb, 1, 2, 1'b0);
        add_action(check_call, 0, 2'b00, 198, 198, 4, pre_flop, role_bb, 0, 2, 1'b0);
        add_action(check_call, 0, 2'b00, 198, 198, 4, flop, role_bb, 0, 2, 1'b0);
        add_action(bet_raise, 5, 2'b00, 198, 193, 9, flop, role_sb, 5, 5, 1'b0);
        add_action(bet_raise, 3, 2'b00, 188, 193, 19, flop, role_bb, 5, 5, 1'b0);
        add_action(check_call, 0, 2'b00, 188, 188, 24, turn, role_bb, 0, 2, 1'b0);
        add_action(check_call, 0, 2'b00, 188, 188, 24, turn, role_sb, 0, 2, 1'b0);
        add_action(check_call, 0, 2'b00, 188, 188, 24, river, role_bb, 0, 2, 1'b0);
        add_action(check_call, 0, 2'b00, 188, 188, 24, river, role_sb, 0, 2, 1'b0);
        add_action(check_call, 0, 2'b10, 188, 212, 0, idle, role_sb, 0, 2, 1'b1);
        // Hand 2, p2 small blind folds; the write mid-hand is dropped
        add_action(check_call, 0, 2'b00, 186, 211, 3, pre_flop, role_sb, 1, 2, 1'b1);
        add_config(addr_sb, 5, 186, 211, 3, pre_flop, role_sb, 1, 2, 1'b1);
        add_action(fold, 0, 2'b00, 189, 211, 0, idle, role_sb, 1, 2, 1'b0);
        // Hand 3, p1 all-in on a call, draw with an odd pot
        add_action(check_call, 0, 2'b00, 188, 209, 3, pre_flop, role_sb, 1, 2, 1'b0);
        add_action(check_call, 0, 2'b00, 187, 209, 4, pre_flop, role_bb, 0, 2, 1'b0);
        add_action(bet_raise, 190, 2'b00, 187, 19, 194, pre_flop, role_sb, 190, 190, 1'b0);
        add_action(check_call, 0, 2'b01, 190, 210, 0, idle, role_sb, 3, 190, 1'b1);
        // Hand 4, both all-in, player 1 wins as big blind
        add_action(check_call, 0, 2'b00, 188, 209, 3, pre_flop, role_sb, 1, 2, 1'b1);
        add_action(bet_raise, 300, 2'b00, 188, 0, 212, pre_flop, role_bb, 208, 300, 1'b1);
        add_action(check_call, 0, 2'b00, 400, 0, 0, idle, role_sb, 0, 300, 1'b0);
        // New blinds and stack between hands, big blind clamped up to 5
        add_config(addr_sb, 5, 400, 0, 0, idle, role_sb, 0, 300, 1'b0);
        add_config(addr_bb, 3, 400, 0, 0, idle, role_sb, 0, 300, 1'b0);
        add_config(addr_stack, 100, 400, 0, 0, idle, role_sb, 0, 300, 1'b0);
        // Hand 5, busted player forces a reload to 100
        add_action(check_call, 0, 2'b00, 95, 95, 10, pre_flop, role_sb, 0, 5, 1'b0);
        add_action(fold, 0, 2'b00, 95, 105, 0, idle, role_sb, 0, 5, 1'b1);
    endtask

    task automatic check_value(input int row, input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at step %0d: %s is %h, expected %h", row, name, got, exp);
        end
    endtask

    task automatic check_row(input int row, input step_t s);
        check_value(row, "p1_stack", p1_stack, s.exp_p1);
        check_value(row, "p2_stack", p2_stack, s.exp_p2);
        check_value(row, "pot", pot, s.exp_pot);
        check_value(row, "street", street, s.exp_street);
        check_value(row, "to_act", to_act, s.exp_to_act);
        check_value(row, "call_amount", call_amount, s.exp_call);
        check_value(row, "min_raise", min_raise, s.exp_min);
        check_value(row, "button", button, s.exp_button);
    endtask

    // Drives on a falling edge and releases the strobe one cycle later
    task automatic apply_step(input step_t s);
        if (s.op == step_act) begin
            eval_answer   = s.res;
            action.kind   = s.kind;
            action.amount = s.amount;
            action_valid  = 1'b1;
        end else begin
            cfg_addr = s.addr;
            cfg_data = s.amount;
            cfg_we   = 1'b1;
        end
        @(negedge clk);
        action_valid = 1'b0;
        cfg_we       = 1'b0;
    endtask

    task automatic finish_run(input logic timed_out);
        $display("Checks: %0d, mismatches: %0d, assertion failures: %0d, timeouts: %0d",
                 checks, mismatches, i_dut.i_asserts.fail_count, timed_out);
        if (!timed_out && mismatches == 0 && i_dut.i_asserts.fail_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    endtask

    // Evaluator: random 0 to 3 cycle delay, then four-phase ack
    initial begin
        int wait_cycles;
        forever begin
            @(negedge clk);
            if (eval_req && !eval_ack) begin
                rand_state = xorshift(rand_state);
                wait_cycles = rand_state % 4;
                repeat (wait_cycles) @(negedge clk);
                eval_result = eval_answer;
                eval_ack    = 1'b1;
                while (eval_req) begin
                    @(negedge clk);
                end
                eval_ack = 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (timeout_limit > 0 && cycles >= timeout_limit) begin
            $display("Timeout: the DUT did not return ready within %0d cycles", timeout_limit);
            finish_run(1'b1);
        end
    end

    initial begin
        step_t s;
        reset        = 1'b1;
        action_valid = 1'b0;
        action       = '0;
        cfg_we       = 1'b0;
        cfg_addr     = addr_sb;
        cfg_data     = '0;
        eval_ack     = 1'b0;
        eval_result  = '0;
        eval_answer  = '0;
        build_table();
        timeout_limit = steps.size() * 30 + 200;

        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // State straight out of reset
        check_value(0, "street", street, idle);
        check_value(0, "ready", ready, 1'b1);
        check_value(0, "eval_req", eval_req, 1'b0);
        check_value(0, "pot", pot, 0);
        check_value(0, "call_amount", call_amount, 0);
        check_value(0, "p1_stack", p1_stack, 0);
        check_value(0, "p2_stack", p2_stack, 0);

        foreach (steps[i]) begin
            s = steps[i];
            apply_step(s);
            while (!ready) begin
                @(negedge clk);
            end
            check_row(i + 1, s);
        end

        finish_run(1'b0);
    end

endmodule

/* compile.f */
+incdir+include
hdl/poker_pkg.sv
hdl/table_config_regs.sv
hdl/hand_sequencer.sv
hdl/betting_round.sv
hdl/chip_ledger.sv
hdl/poker_table_top.sv
verification/poker_table_asserts.sv
verification/poker_table_tb.sv
